// File: filelist.f
+incdir+verilog
verilog/reg_bus_pkg.sv
verilog/reg_bus_if.sv
verilog/apb_reg_bridge.sv
verilog/reg_bus_mux.sv
verilog/hub_regs.sv
verilog/board_regs.sv
verilog/fpga_reg_subsys.sv
verif/tb_fpga_reg_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build the register bus testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

TOP=tb_fpga_reg_subsys
LOG=sim.log

verilator --binary -j 0 --top-module "$TOP" -f filelist.f --Mdir obj_dir -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0

// File: verif/tb_fpga_reg_subsys.sv
// directed testbench for the register bus core
// drives APB and the block writer port, models the external register bus
`default_nettype none

`include "reg_bus_config.svh"

module tb_fpga_reg_subsys;
    import reg_bus_pkg::*;

    localparam int HALF    = 50;     // 100 unit clock period
    localparam int SETTLE  = 10;     // sample point after the falling edge
    localparam int TIMEOUT = 20;     // cycles allowed per wait loop

    logic        sysclk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    reg_addr_t   paddr;
    reg_data_t   pwdata;
    reg_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  board_id;
    logic        bw_write_en;
    logic        bw_reg_wen;
    logic        bw_blk_wen;
    logic        bw_blk_wstart;
    logic [7:0]  bw_reg_waddr;
    reg_data_t   bw_reg_wdata;
    logic        sample_busy;
    logic [3:0]  sample_chan;
    logic        sample_start;
    reg_addr_t   reg_raddr;
    reg_data_t   ext_rdata = '0;     // external register model output
    reg_addr_t   reg_waddr;
    reg_data_t   reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic        blk_wstart;
    logic [15:0] bc_sequence;
    logic        write_trig;
    logic        write_trig_reset;

    reg_data_t   hub_model [`HUB_WORDS];   // expected hub contents

    fpga_reg_subsys dut_i (
        .sysclk          (sysclk),
        .rst             (rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .board_id        (board_id),
        .bw_write_en     (bw_write_en),
        .bw_reg_wen      (bw_reg_wen),
        .bw_blk_wen      (bw_blk_wen),
        .bw_blk_wstart   (bw_blk_wstart),
        .bw_reg_waddr    (bw_reg_waddr),
        .bw_reg_wdata    (bw_reg_wdata),
        .sample_busy     (sample_busy),
        .sample_chan     (sample_chan),
        .sample_start    (sample_start),
        .reg_raddr       (reg_raddr),
        .reg_rdata_ext   (ext_rdata),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .blk_wen         (blk_wen),
        .blk_wstart      (blk_wstart),
        .bc_sequence     (bc_sequence),
        .write_trig      (write_trig),
        .write_trig_reset(write_trig_reset)
    );

    initial begin
        sysclk = 1'b0;
        forever #HALF sysclk = ~sysclk;
    end

    // external registers answer one cycle after the address
    always @(posedge sysclk) begin
        ext_rdata <= {16'hE000, reg_raddr};
    end

    // ------------------------------------------------------------------------
    // reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_stop($sformatf("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    // version in 31:16, pending in bit 8, board id in 3:0
    function automatic reg_data_t status_word(input logic pend);
        reg_data_t w;
        w        = '0;
        w[31:16] = `BOARD_VERSION;
        w[8]     = pend;
        w[3:0]   = board_id;
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // APB host
    // ------------------------------------------------------------------------
    task automatic start_transfer(input logic wr, input reg_addr_t addr, input reg_data_t data);
        @(negedge sysclk);
        psel    = 1'b1;          // setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge sysclk);
        penable = 1'b1;          // first access cycle
    endtask

    // returns the access cycle in which pready came up
    task automatic wait_ready(input string what, output int cycles);
        cycles = 1;
        #SETTLE;
        while (pready !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                fail_stop($sformatf("timeout waiting for pready on %s", what));
            end else begin
                @(negedge sysclk);
                #SETTLE;
                cycles++;
            end
        end
    endtask

    task automatic finish_transfer();
        @(negedge sysclk);       // completing rising edge has passed
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_data_t data, output int cycles);
        start_transfer(1'b1, addr, data);
        wait_ready("write", cycles);
        finish_transfer();
    endtask

    task automatic host_read(input reg_addr_t addr, output reg_data_t data, output int cycles);
        start_transfer(1'b0, addr, '0);
        wait_ready("read", cycles);
        data = prdata;
        check_bit("pslverr", pslverr, 1'b0);
        finish_transfer();
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic after_reset();
        reg_data_t rd;
        int        cyc;
        check_bit("pready", pready, 1'b0);
        check_bit("reg_wen", reg_wen, 1'b0);
        check_bit("blk_wen", blk_wen, 1'b0);
        check_bit("blk_wstart", blk_wstart, 1'b0);
        check_bit("sample_start", sample_start, 1'b0);
        check_bit("write_trig", write_trig, 1'b0);
        host_read(16'h0000, rd, cyc);
        check_data("status", rd, status_word(1'b0));
    endtask

    task automatic hub_memory_rw();
        reg_data_t rd;
        int        cyc;
        for (int i = 0; i < `HUB_WORDS; i++) begin
            hub_model[i] = $urandom;
            host_write({12'h200, i[3:0]}, hub_model[i], cyc);
            check_cycles("write access cycles", cyc, 1);    // no block writer
        end
        for (int i = 0; i < `HUB_WORDS; i++) begin
            host_read({12'h200, i[3:0]}, rd, cyc);
            check_data($sformatf("hub[%0d]", i), rd, hub_model[i]);
            check_cycles("read access cycles", cyc, 2);
        end
        host_read(16'h2010, rd, cyc);                        // one past the end
        check_data("hub past end", rd, '0);
    endtask

    task automatic write_backpressure();
        reg_data_t bw_data;
        reg_data_t host_data;
        reg_data_t rd;
        int        cyc;
        bw_data      = $urandom;
        host_data    = $urandom;
        bw_write_en  = 1'b1;     // block writer takes the bus
        bw_reg_wen   = 1'b1;
        bw_blk_wen   = 1'b1;     // block strobe without start
        bw_reg_waddr = 8'h40;    // unused main offset
        bw_reg_wdata = bw_data;
        start_transfer(1'b1, 16'h2003, host_data);
        for (int k = 0; k < 3; k++) begin
            #SETTLE;
            check_bit("pready while stalled", pready, 1'b0);
            check_addr("reg_waddr", reg_waddr, 16'h0040);   // zero extended
            check_data("reg_wdata", reg_wdata, bw_data);
            check_bit("reg_wen", reg_wen, 1'b1);
            check_bit("blk_wen", blk_wen, 1'b1);
            check_bit("blk_wstart", blk_wstart, 1'b0);
            @(negedge sysclk);
        end
        bw_write_en = 1'b0;
        bw_reg_wen  = 1'b0;
        bw_blk_wen  = 1'b0;
        wait_ready("stalled write", cyc);
        check_addr("reg_waddr", reg_waddr, 16'h2003);    // host write shows up
        check_data("reg_wdata", reg_wdata, host_data);
        check_bit("reg_wen", reg_wen, 1'b1);
        check_bit("blk_wen", blk_wen, 1'b0);             // host never block writes
        finish_transfer();
        hub_model[3] = host_data;
        host_read(16'h2003, rd, cyc);
        check_data("hub[3] after stall", rd, host_data);
    endtask

    task automatic region_routing();
        reg_data_t rd;
        int        cyc;
        host_read(16'h3104, rd, cyc);                     // prom region
        check_data("prom read", rd, {16'hE000, 16'h3104});
        host_read(16'h7a5c, rd, cyc);                     // unused region
        check_data("unused region read", rd, {16'hE000, 16'h7a5c});
        sample_busy = 1'b1;
        sample_chan = 4'h5;
        start_transfer(1'b0, 16'h2005, '0);
        for (int k = 0; k < 3; k++) begin
            #SETTLE;
            check_bit("pready while sampling", pready, 1'b0);
            check_addr("reg_raddr", reg_raddr, 16'h0050);  // main, chan 5 in 7:4
            @(negedge sysclk);
        end
        sample_busy = 1'b0;
        wait_ready("stalled read", cyc);
        check_data("hub[5] after stall", prdata, hub_model[5]);
        finish_transfer();
    endtask

    task automatic sequence_trigger();
        reg_data_t seq_data;
        int        cyc;
        seq_data = $urandom;
        host_write(16'h0002, seq_data, cyc);
        #SETTLE;
        check_bit("write_trig", write_trig, 1'b1);
        check_addr("bc_sequence", bc_sequence, seq_data[15:0]);
        for (int k = 0; k < 3; k++) begin                 // held until reset
            @(negedge sysclk);
            #SETTLE;
            check_bit("write_trig held", write_trig, 1'b1);
        end
        @(negedge sysclk);
        write_trig_reset = 1'b1;
        @(negedge sysclk);
        write_trig_reset = 1'b0;
        #SETTLE;
        check_bit("write_trig after reset", write_trig, 1'b0);
    endtask

    task automatic sample_request();
        reg_data_t rd;
        int        cyc;
        int        waited;
        @(negedge sysclk);
        sample_busy = 1'b1;
        host_write(16'h0001, 32'h0000_0001, cyc);         // request sampling
        for (int k = 0; k < 3; k++) begin
            #SETTLE;
            check_bit("sample_start while busy", sample_start, 1'b0);
            @(negedge sysclk);
        end
        sample_busy = 1'b0;
        waited = 0;
        #SETTLE;
        while (sample_start !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                fail_stop("sample_start never fired after sample_busy dropped");
            end else begin
                @(negedge sysclk);
                #SETTLE;
                waited++;
            end
        end
        for (int k = 0; k < 4; k++) begin                 // single pulse only
            @(negedge sysclk);
            #SETTLE;
            check_bit("sample_start after pulse", sample_start, 1'b0);
        end
        host_read(16'h0000, rd, cyc);
        check_data("status after pulse", rd, status_word(1'b0));
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(47));
        rst              = 1'b1;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        board_id         = 4'h9;
        bw_write_en      = 1'b0;
        bw_reg_wen       = 1'b0;
        bw_blk_wen       = 1'b0;
        bw_blk_wstart    = 1'b0;
        bw_reg_waddr     = '0;
        bw_reg_wdata     = '0;
        sample_busy      = 1'b0;
        sample_chan      = '0;
        write_trig_reset = 1'b0;
        repeat (2) @(negedge sysclk);    // two rising edges in reset
        rst = 1'b0;

        after_reset();
        hub_memory_rw();
        write_backpressure();
        region_routing();
        sequence_trigger();
        sample_request();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/apb_reg_bridge.sv
// APB slave front end for the register bus
// writes complete on wr_gnt, reads one cycle after rd_gnt
`default_nettype none

module apb_reg_bridge (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  reg_bus_pkg::reg_addr_t paddr,
    input  reg_bus_pkg::reg_data_t pwdata,
    output reg_bus_pkg::reg_data_t prdata,
    output logic                  pready,
    reg_bus_if.host               bus
);
    import reg_bus_pkg::*;

    typedef enum logic {
        st_idle,      // no read in flight
        st_rdata      // granted read, data returns this cycle
    } state_e;

    state_e    state;
    logic      access;       // apb access phase
    reg_data_t prdata_q;     // last read word, held after completion

    assign access = psel & penable;

    // --------------------------------------------------------------------
    // request side
    // --------------------------------------------------------------------
    assign bus.wen        = access & pwrite;    // held until granted
    assign bus.blk_wen    = 1'b0;               // host does quadlet writes only
    assign bus.blk_wstart = 1'b0;
    assign bus.waddr      = paddr;
    assign bus.wdata      = pwdata;
    assign bus.raddr      = paddr;
    // no second request while data is coming back
    assign bus.rd_en      = access & ~pwrite & (state == st_idle);

    // read wait tracking
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (bus.rd_gnt) begin
                        state <= st_rdata;
                    end
                end
                st_rdata: state <= st_idle;     // one data cycle only
                default:  state <= st_idle;
            endcase
        end
    end

    // capture the returning word
    always_ff @(posedge sysclk) begin
        if (state == st_rdata) begin
            prdata_q <= bus.rdata;
        end
    end

    // --------------------------------------------------------------------
    // completion
    // --------------------------------------------------------------------
    assign pready = (state == st_rdata) | (bus.wen & bus.wr_gnt);
    assign prdata = (state == st_rdata) ? bus.rdata : prdata_q;

endmodule

`default_nettype wire

// File: verilog/board_regs.sv
// board status and control registers in the main region
// control bit 0 queues a sample request, fired once the sampler is free
`default_nettype none

`include "reg_bus_config.svh"

module board_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    reg_bus_if.slave              bus,
    input  logic [3:0]            board_id,
    input  logic                  sample_busy,
    output reg_bus_pkg::reg_data_t rdata,
    output logic                  sample_start    // one cycle pulse
);
    import reg_bus_pkg::*;

    logic      ctrl_wr;      // control register write
    logic      pending;      // sample request waiting
    reg_data_t status;

    assign ctrl_wr = bus.wen && (addr_region(bus.waddr) == region_main)
                     && (bus.waddr[11:0] == `BOARD_OFS_CTRL);

    // ------------------------------------------------------------------
    // sample request
    // ------------------------------------------------------------------
    assign sample_start = pending & ~sample_busy;   // gated by the sampler

    always_ff @(posedge sysclk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (ctrl_wr && bus.wdata[0]) begin
            pending <= 1'b1;
        end else if (sample_start) begin
            pending <= 1'b0;          // request consumed
        end
    end

    // version | pending | board id
    assign status = {`BOARD_VERSION, 7'd0, pending, 4'd0, board_id};

    // registered read, unused offsets give zero
    always_ff @(posedge sysclk) begin
        if (bus.rd_en) begin
            rdata <= (bus.raddr[11:0] == `BOARD_OFS_STATUS) ? status : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fpga_reg_subsys.sv
// top of the register bus core: APB host port, block writer port,
// external register bus and sampler hooks, all as plain ports
`default_nettype none

module fpga_reg_subsys (
    input  logic                  sysclk,
    input  logic                  rst,

    // apb host
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  reg_bus_pkg::reg_addr_t paddr,
    input  reg_bus_pkg::reg_data_t pwdata,
    output reg_bus_pkg::reg_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,

    input  logic [3:0]            board_id,      // rotary switch

    // block write support
    input  logic                  bw_write_en,
    input  logic                  bw_reg_wen,
    input  logic                  bw_blk_wen,
    input  logic                  bw_blk_wstart,
    input  logic [7:0]            bw_reg_waddr,
    input  reg_bus_pkg::reg_data_t bw_reg_wdata,

    // sampling
    input  logic                  sample_busy,
    input  logic [3:0]            sample_chan,
    output logic                  sample_start,

    // external register bus
    output reg_bus_pkg::reg_addr_t reg_raddr,
    input  reg_bus_pkg::reg_data_t reg_rdata_ext,  // one cycle after reg_raddr
    output reg_bus_pkg::reg_addr_t reg_waddr,
    output reg_bus_pkg::reg_data_t reg_wdata,
    output logic                  reg_wen,
    output logic                  blk_wen,
    output logic                  blk_wstart,

    // hub broadcast
    output logic [15:0]           bc_sequence,
    output logic                  write_trig,
    input  logic                  write_trig_reset
);
    import reg_bus_pkg::*;

    reg_data_t rdata_hub;
    reg_data_t rdata_board;

    reg_bus_if host_bus ();    // bridge to mux
    reg_bus_if slv_bus ();     // arbitrated bus to the register blocks

    assign pslverr = 1'b0;     // every access completes cleanly

    apb_reg_bridge bridge_i (
        .sysclk (sysclk),
        .rst    (rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .bus    (host_bus.host)
    );

    reg_bus_mux mux_i (
        .sysclk       (sysclk),
        .host         (host_bus.arb),
        .bw_write_en  (bw_write_en),
        .bw_reg_wen   (bw_reg_wen),
        .bw_blk_wen   (bw_blk_wen),
        .bw_blk_wstart(bw_blk_wstart),
        .bw_reg_waddr (bw_reg_waddr),
        .bw_reg_wdata (bw_reg_wdata),
        .sample_busy  (sample_busy),
        .sample_chan  (sample_chan),
        .wr           (slv_bus.host),
        .rdata_hub    (rdata_hub),
        .rdata_board  (rdata_board),
        .rdata_ext    (reg_rdata_ext)
    );

    hub_regs hub_i (
        .sysclk          (sysclk),
        .rst             (rst),
        .bus             (slv_bus.slave),
        .board_id        (board_id),
        .write_trig_reset(write_trig_reset),
        .rdata           (rdata_hub),
        .bc_sequence     (bc_sequence),
        .write_trig      (write_trig)
    );

    board_regs board_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .bus         (slv_bus.slave),
        .board_id    (board_id),
        .sample_busy (sample_busy),
        .rdata       (rdata_board),
        .sample_start(sample_start)
    );

    // arbitrated bus out to the external registers
    assign reg_raddr  = slv_bus.raddr;
    assign reg_waddr  = slv_bus.waddr;
    assign reg_wdata  = slv_bus.wdata;
    assign reg_wen    = slv_bus.wen;
    assign blk_wen    = slv_bus.blk_wen;
    assign blk_wstart = slv_bus.blk_wstart;

endmodule

`default_nettype wire

// File: verilog/hub_regs.sv
// hub memory plus broadcast sequence register and write trigger
// sits on the arbitrated slave bus, read data is registered
`default_nettype none

`include "reg_bus_config.svh"

module hub_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    reg_bus_if.slave              bus,
    input  logic [3:0]            board_id,
    input  logic                  write_trig_reset,   // broadcast done
    output reg_bus_pkg::reg_data_t rdata,
    output logic [15:0]           bc_sequence,
    output logic                  write_trig
);
    import reg_bus_pkg::*;

    localparam int HUB_AW = $clog2(`HUB_WORDS);

    reg_data_t         mem [`HUB_WORDS];
    logic              hub_wr;        // write lands in hub memory
    logic [HUB_AW-1:0] wr_idx;
    logic              seq_wr;        // sequence register write
    logic              rd_in_range;

    // --------------------------------------------------------------------
    // hub memory
    // --------------------------------------------------------------------
    assign hub_wr = bus.wen && (addr_region(bus.waddr) == region_hub)
                    && (bus.waddr[11:HUB_AW] == '0);
    // block writes fill this board's own slot
    assign wr_idx = bus.blk_wen ? board_id[HUB_AW-1:0] : bus.waddr[HUB_AW-1:0];

    always_ff @(posedge sysclk) begin
        if (hub_wr) begin
            mem[wr_idx] <= bus.wdata;
        end
    end

    assign rd_in_range = (bus.raddr[11:HUB_AW] == '0);

    always_ff @(posedge sysclk) begin
        if (bus.rd_en) begin
            rdata <= rd_in_range ? mem[bus.raddr[HUB_AW-1:0]] : '0;   // past end
        end
    end

    // --------------------------------------------------------------------
    // broadcast sequence and trigger
    // --------------------------------------------------------------------
    assign seq_wr = bus.wen && (addr_region(bus.waddr) == region_main)
                    && (bus.waddr[11:0] == `BOARD_OFS_SEQ);

    always_ff @(posedge sysclk) begin
        if (seq_wr) begin
            bc_sequence <= bus.wdata[15:0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            write_trig <= 1'b0;
        end else if (seq_wr) begin
            write_trig <= 1'b1;           // new sequence, go broadcast
        end else if (write_trig_reset) begin
            write_trig <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_bus_config.svh
// register bus constants shared by the package and the slave blocks
// include wherever region codes, hub depth or board offsets are needed
`ifndef REG_BUS_CONFIG_SVH
`define REG_BUS_CONFIG_SVH

// ------------------------------------------------------------------------
// region codes, carried in addr[15:12]
// ------------------------------------------------------------------------
`define ADDR_MAIN   4'd0        // board registers
`define ADDR_HUB    4'd2        // hub memory
`define ADDR_PROM   4'd3        // prom, served by the external path
`define ADDR_EXT    4'hf        // catch-all code for unmatched regions

// hub memory depth in words
`define HUB_WORDS   16

// ------------------------------------------------------------------------
// offsets inside the main region, addr[11:0]
// ------------------------------------------------------------------------
`define BOARD_OFS_STATUS  12'd0   // status word, read only
`define BOARD_OFS_CTRL    12'd1   // control, bit 0 requests sampling
`define BOARD_OFS_SEQ     12'd2   // broadcast sequence, owned by the hub

// firmware version, lands in status bits 31:16
`define BOARD_VERSION  16'h0107

`endif

// File: verilog/reg_bus_if.sv
// internal register bus: write port, read port and their grants
// host modport on the requester, arb on the mux, slave on register blocks
`default_nettype none

interface reg_bus_if;
    import reg_bus_pkg::*;

    logic      wen;          // register write strobe
    logic      blk_wen;      // block write strobe
    logic      blk_wstart;   // block write starting
    reg_addr_t waddr;
    reg_data_t wdata;
    reg_addr_t raddr;
    logic      rd_en;        // read request, or granted read on slave side
    reg_data_t rdata;        // valid one cycle after rd_gnt
    logic      wr_gnt;
    logic      rd_gnt;

    modport host (
        output wen, blk_wen, blk_wstart, waddr, wdata, raddr, rd_en,
        input  wr_gnt, rd_gnt, rdata
    );

    modport arb (
        input  wen, blk_wen, blk_wstart, waddr, wdata, raddr, rd_en,
        output wr_gnt, rd_gnt, rdata
    );

    // register blocks only listen
    modport slave (
        input  wen, blk_wen, blk_wstart, waddr, wdata, raddr, rd_en
    );

endinterface

`default_nettype wire

// File: verilog/reg_bus_mux.sv
// write bus arbitration between host and block writer, read address
// override for the sampler, and region based routing of read data
`default_nettype none

`include "reg_bus_config.svh"

module reg_bus_mux (
    input  logic                  sysclk,
    reg_bus_if.arb                host,
    input  logic                  bw_write_en,     // block writer owns the bus
    input  logic                  bw_reg_wen,
    input  logic                  bw_blk_wen,
    input  logic                  bw_blk_wstart,
    input  logic [7:0]            bw_reg_waddr,
    input  reg_bus_pkg::reg_data_t bw_reg_wdata,
    input  logic                  sample_busy,     // sampler owns raddr
    input  logic [3:0]            sample_chan,
    reg_bus_if.host               wr,              // drives the slave bus
    input  reg_bus_pkg::reg_data_t rdata_hub,
    input  reg_bus_pkg::reg_data_t rdata_board,
    input  reg_bus_pkg::reg_data_t rdata_ext
);
    import reg_bus_pkg::*;

    logic    rd_gnt;
    region_e rd_region_q;    // region of the read in flight

    // --------------------------------------------------------------------
    // write side, block writer wins whenever enabled
    // --------------------------------------------------------------------
    assign host.wr_gnt = host.wen & ~bw_write_en;

    always_comb begin
        if (bw_write_en) begin
            wr.wen        = bw_reg_wen;
            wr.blk_wen    = bw_blk_wen;
            wr.blk_wstart = bw_blk_wstart;
            wr.waddr      = {8'd0, bw_reg_waddr};   // zero extend
            wr.wdata      = bw_reg_wdata;
        end else begin
            wr.wen        = host.wen;               // granted this cycle
            wr.blk_wen    = host.blk_wen;
            wr.blk_wstart = host.blk_wstart;
            wr.waddr      = host.waddr;
            wr.wdata      = host.wdata;
        end
    end

    // --------------------------------------------------------------------
    // read side
    // --------------------------------------------------------------------
    assign rd_gnt      = host.rd_en & ~sample_busy;
    assign host.rd_gnt = rd_gnt;
    assign wr.rd_en    = rd_gnt;                    // slaves load only on grant

    // sampler walks the channels in the main region
    assign wr.raddr = sample_busy ? {`ADDR_MAIN, 4'd0, sample_chan, 4'd0}
                                  : host.raddr;

    always_ff @(posedge sysclk) begin
        if (rd_gnt) begin
            rd_region_q <= addr_region(host.raddr);
        end
    end

    // every source is registered, so route on the stored region
    always_comb begin
        case (rd_region_q)
            region_hub:  host.rdata = rdata_hub;
            region_main: host.rdata = rdata_board;
            default:     host.rdata = rdata_ext;   // prom and the rest
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_bus_pkg.sv
// types shared across the register bus core
// compile first, every block imports it
`default_nettype none

`include "reg_bus_config.svh"

package reg_bus_pkg;

    typedef logic [15:0] reg_addr_t;    // region in bits 15:12
    typedef logic [31:0] reg_data_t;    // one register word

    // read source selector, codes match the region field
    typedef enum logic [3:0] {
        region_main = `ADDR_MAIN,
        region_hub  = `ADDR_HUB,
        region_prom = `ADDR_PROM,
        region_ext  = `ADDR_EXT
    } region_e;

    // decode the region field of an address
    function automatic region_e addr_region(input reg_addr_t addr);
        case (addr[15:12])
            `ADDR_MAIN: return region_main;
            `ADDR_HUB:  return region_hub;
            `ADDR_PROM: return region_prom;
            default:    return region_ext;    // all others go external
        endcase
    endfunction

endpackage

`default_nettype wire
